//--- cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;    // instruction, data or pc word
    typedef logic [3:0]  reg_idx_t; // register index
    typedef logic [6:0]  opcode_t;
    typedef logic [3:0]  cond_t;
    typedef logic [1:0]  sel_t;     // operand source select
    typedef logic [4:0]  imm5_t;    // immediate shift amount

    // field positions in the instruction word
    localparam int COND_HI      = 31;
    localparam int COND_LO      = 28;
    localparam int OPCODE_HI    = 27;
    localparam int OPCODE_LO    = 21;
    localparam int EN_STATUS_B  = 20;
    localparam int RN_HI        = 19;
    localparam int RN_LO        = 16;
    localparam int RD_HI        = 15;
    localparam int RD_LO        = 12;
    localparam int RS_HI        = 11;
    localparam int RS_LO        = 8;
    localparam int IMM5_HI      = 11;
    localparam int IMM5_LO      = 7;
    localparam int SHIFT_OP_HI  = 6;
    localparam int SHIFT_OP_LO  = 5;
    localparam int RM_HI        = 3;
    localparam int RM_LO        = 0;

    localparam cond_t COND_NEVER = 4'b1111; // not a normal instruction

    // source select codes
    localparam sel_t SEL_RF   = 2'b00;  // register file value
    localparam sel_t SEL_FWD  = 2'b01;  // forwarded alu result
    localparam sel_t SEL_PC   = 2'b11;  // pc, A operand only
    localparam sel_t SEL_ZERO = 2'b11;  // zero, shift operand only

endpackage

//--- pipeline_unit.sv
`timescale 1ns/1ps

module pipeline_unit (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::word_t   instr_in,
    input  logic             branch_in,   // flush request
    input  logic             sel_stall,   // hazard stall
    output cpu_pkg::cond_t   cond,
    output cpu_pkg::opcode_t opcode,
    output logic             en_status,
    output cpu_pkg::reg_idx_t rn,
    output cpu_pkg::reg_idx_t rd,
    output cpu_pkg::reg_idx_t rs,
    output cpu_pkg::reg_idx_t rm,
    output logic [1:0]       shift_op,
    output cpu_pkg::imm5_t   imm5,
    output logic             branch_value,
    output cpu_pkg::word_t   instr_output
);

    cpu_pkg::word_t instr_q;    // word held between decode and execute
    logic           bubble_q;   // set when the held word is a flush bubble

    // flush wins over stall, stall keeps the old word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_q  <= '0;
            bubble_q <= 1'b0;
        end else if (branch_in) begin
            instr_q  <= '0;     // all-zero bubble
            bubble_q <= 1'b1;
        end else if (!sel_stall) begin
            instr_q  <= instr_in;
            bubble_q <= 1'b0;
        end
    end

    // field slices of the held word
    assign cond      = instr_q[cpu_pkg::COND_HI:cpu_pkg::COND_LO];
    assign opcode    = instr_q[cpu_pkg::OPCODE_HI:cpu_pkg::OPCODE_LO];
    assign en_status = instr_q[cpu_pkg::EN_STATUS_B];
    assign rn        = instr_q[cpu_pkg::RN_HI:cpu_pkg::RN_LO];
    assign rd        = instr_q[cpu_pkg::RD_HI:cpu_pkg::RD_LO];
    assign rs        = instr_q[cpu_pkg::RS_HI:cpu_pkg::RS_LO];
    assign imm5      = instr_q[cpu_pkg::IMM5_HI:cpu_pkg::IMM5_LO];   // overlaps rs
    assign shift_op  = instr_q[cpu_pkg::SHIFT_OP_HI:cpu_pkg::SHIFT_OP_LO];
    assign rm        = instr_q[cpu_pkg::RM_HI:cpu_pkg::RM_LO];

    assign branch_value = bubble_q;
    assign instr_output = instr_q;

endmodule

//--- execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::word_t    instr_in,
    input  logic              branch_in,
    input  logic              sel_stall,
    input  cpu_pkg::reg_idx_t rd,           // memory stage destination
    output cpu_pkg::opcode_t  opcode,
    output cpu_pkg::reg_idx_t rn,
    output cpu_pkg::reg_idx_t rs,
    output cpu_pkg::reg_idx_t rm,
    output cpu_pkg::imm5_t    imm5,
    output logic              branch_value,
    output cpu_pkg::word_t    instr_output,
    output cpu_pkg::sel_t     sel_a_in,
    output cpu_pkg::sel_t     sel_b_in,
    output cpu_pkg::sel_t     sel_shift_in,
    output logic              sel_shift,     // 1 = shift amount from a register
    output logic              en_a,
    output logic              en_b,
    output logic              en_s
);

    cpu_pkg::cond_t cond;

    logic is_normal;
    logic is_ldst;
    logic is_branch;

    pipeline_unit u_pipe (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_in     (instr_in),
        .branch_in    (branch_in),
        .sel_stall    (sel_stall),
        .cond         (cond),
        .opcode       (opcode),
        .en_status    (),
        .rn           (rn),
        .rd           (),
        .rs           (rs),
        .rm           (rm),
        .shift_op     (),
        .imm5         (imm5),
        .branch_value (branch_value),
        .instr_output (instr_output)
    );

    // instruction classes
    assign is_normal = !opcode[6] && (opcode[5:4] != 2'b10) && (cond != cpu_pkg::COND_NEVER);
    assign is_ldst   = (opcode[6:5] == 2'b11) || (opcode[6:3] == 4'b1000);
    assign is_branch = (opcode[6:3] == 4'b1001);

    always_comb begin
        // forwarding by index match only, no valid bit
        sel_a_in     = (rn == rd) ? cpu_pkg::SEL_FWD : cpu_pkg::SEL_RF;
        sel_b_in     = (rm == rd) ? cpu_pkg::SEL_FWD : cpu_pkg::SEL_RF;
        sel_shift_in = (rs == rd) ? cpu_pkg::SEL_FWD : cpu_pkg::SEL_RF;
        sel_shift    = 1'b0;
        en_a         = 1'b0;
        en_b         = 1'b0;
        en_s         = 1'b0;

        if (is_normal) begin
            if (opcode[4]) begin    // shifted second operand
                sel_shift = opcode[5];
                en_b      = 1'b1;
                en_s      = 1'b1;
            end
            if (opcode[3]) begin
                en_a = 1'b1;
            end
        end else if (is_ldst) begin
            if (!opcode[3]) begin
                // immediate offset form
                if (opcode[6:4] == 3'b100) begin
                    sel_a_in = cpu_pkg::SEL_PC;  // literal load, base is pc
                end
                en_a = 1'b1;
            end else begin
                // register offset form
                sel_shift = 1'b1;
                en_a      = 1'b1;
                en_b      = 1'b1;
                en_s      = 1'b1;
            end
        end else if (is_branch) begin
            if (!opcode[0]) begin
                sel_a_in = cpu_pkg::SEL_PC;      // pc relative target
            end else begin
                en_b = 1'b1;                     // target from rm
            end
            sel_shift    = 1'b1;
            sel_shift_in = cpu_pkg::SEL_ZERO;    // no shift on branch
            en_s         = 1'b1;
        end
    end

endmodule

//--- operand_datapath.sv
`timescale 1ns/1ps

module operand_datapath (
    input  logic           clk,
    input  logic           rst_n,
    input  cpu_pkg::sel_t  sel_a_in,
    input  cpu_pkg::sel_t  sel_b_in,
    input  cpu_pkg::sel_t  sel_shift_in,
    input  logic           sel_shift,
    input  logic           en_a,
    input  logic           en_b,
    input  logic           en_s,
    input  cpu_pkg::imm5_t imm5,
    input  cpu_pkg::word_t rf_rn_data,
    input  cpu_pkg::word_t rf_rm_data,
    input  cpu_pkg::word_t rf_rs_data,
    input  cpu_pkg::word_t alu_result,    // forward value
    input  cpu_pkg::word_t pc,
    output cpu_pkg::word_t val_a,
    output cpu_pkg::word_t val_b,
    output cpu_pkg::imm5_t shift_amt
);

    cpu_pkg::word_t a_next;
    cpu_pkg::word_t b_next;
    cpu_pkg::word_t s_reg_val;    // register source of the shift amount
    cpu_pkg::imm5_t s_next;

    // A operand source
    always_comb begin
        case (sel_a_in)
            cpu_pkg::SEL_FWD: a_next = alu_result;
            cpu_pkg::SEL_PC:  a_next = pc;
            default:          a_next = rf_rn_data;
        endcase
    end

    // B operand has no pc path
    assign b_next = (sel_b_in == cpu_pkg::SEL_FWD) ? alu_result : rf_rm_data;

    always_comb begin
        case (sel_shift_in)
            cpu_pkg::SEL_FWD:  s_reg_val = alu_result;
            cpu_pkg::SEL_ZERO: s_reg_val = '0;
            default:           s_reg_val = rf_rs_data;
        endcase
    end

    // only the low five bits count as a shift amount
    assign s_next = sel_shift ? s_reg_val[4:0] : imm5;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            val_a     <= '0;
            val_b     <= '0;
            shift_amt <= '0;
        end else begin
            if (en_a) begin
                val_a <= a_next;
            end
            if (en_b) begin
                val_b <= b_next;
            end
            if (en_s) begin
                shift_amt <= s_next;
            end
        end
    end

endmodule

//--- execute_top.sv
`timescale 1ns/1ps

module execute_top (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::word_t    instr_in,
    input  logic              branch_in,
    input  logic              sel_stall,
    input  cpu_pkg::reg_idx_t rd,
    input  cpu_pkg::word_t    alu_result,
    input  cpu_pkg::word_t    rf_rn_data,
    input  cpu_pkg::word_t    rf_rm_data,
    input  cpu_pkg::word_t    rf_rs_data,
    input  cpu_pkg::word_t    pc,
    output cpu_pkg::opcode_t  opcode,
    output cpu_pkg::reg_idx_t rn,      // register file read indices
    output cpu_pkg::reg_idx_t rs,
    output cpu_pkg::reg_idx_t rm,
    output logic              branch_value,
    output cpu_pkg::word_t    instr_output,
    output logic              en_a,
    output logic              en_b,
    output logic              en_s,
    output cpu_pkg::word_t    val_a,
    output cpu_pkg::word_t    val_b,
    output cpu_pkg::imm5_t    shift_amt
);

    // controller to datapath
    cpu_pkg::sel_t  sel_a_in;
    cpu_pkg::sel_t  sel_b_in;
    cpu_pkg::sel_t  sel_shift_in;
    logic           sel_shift;
    cpu_pkg::imm5_t imm5;

    execute_unit u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_in     (instr_in),
        .branch_in    (branch_in),
        .sel_stall    (sel_stall),
        .rd           (rd),
        .opcode       (opcode),
        .rn           (rn),
        .rs           (rs),
        .rm           (rm),
        .imm5         (imm5),
        .branch_value (branch_value),
        .instr_output (instr_output),
        .sel_a_in     (sel_a_in),
        .sel_b_in     (sel_b_in),
        .sel_shift_in (sel_shift_in),
        .sel_shift    (sel_shift),
        .en_a         (en_a),
        .en_b         (en_b),
        .en_s         (en_s)
    );

    operand_datapath u_opnd (
        .clk          (clk),
        .rst_n        (rst_n),
        .sel_a_in     (sel_a_in),
        .sel_b_in     (sel_b_in),
        .sel_shift_in (sel_shift_in),
        .sel_shift    (sel_shift),
        .en_a         (en_a),
        .en_b         (en_b),
        .en_s         (en_s),
        .imm5         (imm5),
        .rf_rn_data   (rf_rn_data),
        .rf_rm_data   (rf_rm_data),
        .rf_rs_data   (rf_rs_data),
        .alu_result   (alu_result),
        .pc           (pc),
        .val_a        (val_a),
        .val_b        (val_b),
        .shift_amt    (shift_amt)
    );

endmodule

//--- execute_props.sv
`timescale 1ns/1ps

module execute_props (
    input logic              clk,
    input logic              rst_n,
    input cpu_pkg::word_t    instr_in,
    input logic              branch_in,
    input logic              sel_stall,
    input cpu_pkg::opcode_t  opcode,
    input cpu_pkg::reg_idx_t rn,
    input cpu_pkg::reg_idx_t rs,
    input cpu_pkg::reg_idx_t rm,
    input logic              branch_value,
    input cpu_pkg::word_t    instr_output,
    input logic              en_a,
    input logic              en_b,
    input logic              en_s
);

    int fail_count;     // read back by the testbench

    initial fail_count = 0;

    // {en_a, en_b, en_s} that the class of the held word should raise
    function automatic logic [2:0] class_enables(input cpu_pkg::word_t w);
        logic [6:0] op;
        op = w[cpu_pkg::OPCODE_HI:cpu_pkg::OPCODE_LO];
        if (!op[6] && op[5:4] != 2'b10 && w[31:28] != cpu_pkg::COND_NEVER) begin
            return {op[3], op[4], op[4]};
        end else if (op[6:5] == 2'b11 || op[6:3] == 4'b1000) begin
            return op[3] ? 3'b111 : 3'b100;     // register or immediate offset
        end else if (op[6:3] == 4'b1001) begin
            return {1'b0, op[0], 1'b1};
        end
        return 3'b000;
    endfunction

    // a normal load also clears the bubble flag
    capture_fields: assert property (@(posedge clk) disable iff (!rst_n)
        (!branch_in && !sel_stall) |=> (instr_output == $past(instr_in)
            && opcode == $past(instr_in[cpu_pkg::OPCODE_HI:cpu_pkg::OPCODE_LO])
            && rn == $past(instr_in[cpu_pkg::RN_HI:cpu_pkg::RN_LO])
            && rs == $past(instr_in[cpu_pkg::RS_HI:cpu_pkg::RS_LO])
            && rm == $past(instr_in[cpu_pkg::RM_HI:cpu_pkg::RM_LO])
            && !branch_value))
        else begin
            fail_count++;
            $error("fields do not match the word taken on the previous edge");
        end

    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (!branch_in && sel_stall) |=> ($stable(instr_output) && $stable(opcode)
            && $stable(rn) && $stable(rs) && $stable(rm)))
        else begin
            fail_count++;
            $error("held instruction changed during a stall");
        end

    // flush wins even with a stall on the same edge
    flush_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        branch_in |=> (instr_output == '0 && branch_value))
        else begin
            fail_count++;
            $error("flush did not load a bubble");
        end

    class_enable_check: assert property (@(posedge clk) disable iff (!rst_n)
        {en_a, en_b, en_s} == class_enables(instr_output))
        else begin
            fail_count++;
            $error("operand enables do not follow the instruction class");
        end

    reset_enables: assert property (@(posedge clk) !rst_n |-> !(en_a || en_b || en_s))
        else begin
            fail_count++;
            $error("operand enables active during reset");
        end

endmodule

bind execute_top execute_props u_props (.*);

//--- tb_execute_top.sv
`timescale 1ns/1ps

module tb_execute_top;

    logic              clk;
    logic              rst_n;
    cpu_pkg::word_t    instr_in;
    logic              branch_in;
    logic              sel_stall;
    cpu_pkg::reg_idx_t rd;
    cpu_pkg::word_t    alu_result;
    cpu_pkg::word_t    rf_rn_data;
    cpu_pkg::word_t    rf_rm_data;
    cpu_pkg::word_t    rf_rs_data;
    cpu_pkg::word_t    pc;
    cpu_pkg::opcode_t  opcode;
    cpu_pkg::reg_idx_t rn;
    cpu_pkg::reg_idx_t rs;
    cpu_pkg::reg_idx_t rm;
    logic              branch_value;
    cpu_pkg::word_t    instr_output;
    logic              en_a;
    logic              en_b;
    logic              en_s;
    cpu_pkg::word_t    val_a;
    cpu_pkg::word_t    val_b;
    cpu_pkg::imm5_t    shift_amt;

    integer         seed;
    int             errors;
    int             timeouts;
    cpu_pkg::word_t rnd;
    cpu_pkg::word_t m_instr;    // model of the held word
    cpu_pkg::word_t m_a;
    cpu_pkg::word_t m_b;
    cpu_pkg::imm5_t m_s;

    // normal x4, shifted by register, ldst imm, literal, ldst reg, branch imm and reg
    cpu_pkg::opcode_t class_ops [0:9] = '{7'b0000000, 7'b0001000, 7'b0010000, 7'b0011000,
        7'b0111000, 7'b1100000, 7'b1000000, 7'b1101000, 7'b1001000, 7'b1001001};

    execute_top dut (.*);

    always #20 clk = ~clk;

    function automatic cpu_pkg::word_t forwarded(input cpu_pkg::reg_idx_t idx,
                                                 input cpu_pkg::word_t rf_val);
        return (idx == rd) ? alu_result : rf_val;
    endfunction

    always @(posedge clk) begin : ref_model
        cpu_pkg::opcode_t op;
        cpu_pkg::word_t   s_src;
        logic             normal, ldst, brn, ea, eb, es, reg_sh, use_pc;
        op     = m_instr[cpu_pkg::OPCODE_HI:cpu_pkg::OPCODE_LO];
        normal = !op[6] && op[5:4] != 2'b10 && m_instr[31:28] != 4'hf;
        ldst   = op[6:5] == 2'b11 || op[6:3] == 4'b1000;
        brn    = op[6:3] == 4'b1001;
        ea     = normal ? op[3] : ldst;
        eb     = normal ? op[4] : (ldst ? op[3] : brn && op[0]);
        es     = normal ? op[4] : (ldst ? op[3] : brn);
        reg_sh = normal ? op[5] : 1'b1;    // only looked at when es is set
        use_pc = (ldst && op[6:3] == 4'b1000) || (brn && !op[0]);
        s_src  = brn ? '0 : forwarded(m_instr[11:8], rf_rs_data);
        if (!rst_n) begin
            m_instr = '0;
            m_a     = '0;
            m_b     = '0;
            m_s     = '0;
        end else begin
            m_a = ea ? (use_pc ? pc : forwarded(m_instr[19:16], rf_rn_data)) : m_a;
            m_b = eb ? forwarded(m_instr[3:0], rf_rm_data) : m_b;
            m_s = es ? (reg_sh ? s_src[4:0] : m_instr[11:7]) : m_s;
            if (branch_in) begin
                m_instr = '0;
            end else if (!sel_stall) begin
                m_instr = instr_in;
            end
        end
    end

    task automatic mismatch(input string name, input cpu_pkg::word_t got,
                            input cpu_pkg::word_t exp);
        errors++;
        $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    endtask

    // operand registers are settled by the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            assert (val_a === m_a) else mismatch("val_a", val_a, m_a);
            assert (val_b === m_b) else mismatch("val_b", val_b, m_b);
            assert (shift_amt === m_s) else mismatch("shift_amt", 32'(shift_amt), 32'(m_s));
        end
    end

    // keeps rn, rs and rm in 0..3 so they meet rd often
    function automatic cpu_pkg::word_t encode(input cpu_pkg::cond_t c,
                                              input cpu_pkg::opcode_t op,
                                              input cpu_pkg::word_t r);
        cpu_pkg::word_t w;
        w = r;
        w[cpu_pkg::COND_HI:cpu_pkg::COND_LO]     = c;
        w[cpu_pkg::OPCODE_HI:cpu_pkg::OPCODE_LO] = op;
        w[19:18] = 2'b00;
        w[11:10] = 2'b00;
        w[3:2]   = 2'b00;
        return w;
    endfunction

    task automatic drive(input cpu_pkg::word_t instr, input logic flush, input logic stall);
        cpu_pkg::word_t r;
        @(posedge clk);
        #2;
        r          = $random(seed);
        instr_in   = instr;
        branch_in  = flush;
        sel_stall  = stall;
        rd         = {2'b00, r[1:0]};
        alu_result = $random(seed);
        rf_rn_data = $random(seed);
        rf_rm_data = $random(seed);
        rf_rs_data = $random(seed);
        pc         = $random(seed);
    endtask

    task automatic wait_bubble();
        int n;
        n = 0;
        while (branch_value !== 1'b1 && n < 4) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (branch_value !== 1'b1) begin
            timeouts++;
            $display("timeout: the flush bubble never reached the execute register");
        end
    endtask

    initial begin
        seed       = 32'h2d2f;
        errors     = 0;
        timeouts   = 0;
        clk        = 1'b0;
        rst_n      = 1'b0;
        instr_in   = '0;
        branch_in  = 1'b0;
        sel_stall  = 1'b0;
        rd         = '0;
        alu_result = '0;
        rf_rn_data = '0;
        rf_rm_data = '0;
        rf_rs_data = '0;
        pc         = '0;
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        foreach (class_ops[i]) begin
            drive(encode(4'he, class_ops[i], $random(seed)), 1'b0, 1'b0);
        end
        drive(encode(4'hf, 7'b0011000, $random(seed)), 1'b0, 1'b0);  // never condition
        drive(encode(4'he, 7'b1101000, $random(seed)), 1'b0, 1'b0);
        drive(encode(4'he, 7'b0011000, $random(seed)), 1'b0, 1'b1);  // held, re-captures
        drive(encode(4'he, 7'b0001000, $random(seed)), 1'b0, 1'b1);
        drive(encode(4'he, 7'b0011000, $random(seed)), 1'b1, 1'b1);  // flush over stall
        wait_bubble();
        repeat (400) begin
            rnd = $random(seed);
            drive(rnd[0] ? encode(rnd[11:8], rnd[18:12], $random(seed)) : $random(seed),
                  rnd[4:2] == 3'b000, rnd[7:5] == 3'b000);
        end
        repeat (3) drive('0, 1'b0, 1'b0);
        $display("errors: %0d check, %0d assertion, %0d timeout",
                 errors, dut.u_props.fail_count, timeouts);
        if (errors == 0 && timeouts == 0 && dut.u_props.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
cpu_pkg.sv
pipeline_unit.sv
execute_unit.sv
operand_datapath.sv
execute_top.sv
execute_props.sv
tb_execute_top.sv
